// File: build.f
hw/cu_setup_pkg.sv
hw/cu_setup_sync_fifo.sv
hw/cu_setup_read_engine.sv
hw/cu_setup_ctrl.sv
hw/cu_setup_wb_master.sv
hw/cu_setup.sv
verification/cu_setup_tb_clk.sv
verification/cu_setup_tb.sv

// File: hw/cu_setup.sv
// Setup unit top. Reads desc_count consecutive words from desc_base and
// streams them out in order. The stream is the head of the response FIFO.
module cu_setup import cu_setup_pkg::*; #(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 12
) (
    input  logic   ap_clk,
    input  logic   areset_cu_setup,
    input  logic   desc_valid,
    input  addr_t  desc_base,
    input  count_t desc_count,
    output logic   wb_cyc,
    output logic   wb_stb,
    output addr_t  wb_adr,
    input  logic   wb_ack,
    input  data_t  wb_dat_i,
    output logic   setup_valid,
    output data_t  setup_data,
    input  logic   setup_ready,
    output logic   done
);

    // ------------------------------
    // Internal wires
    // ------------------------------
    logic  engine_start;
    logic  engine_pause;
    logic  engine_busy;
    logic  engine_done;
    logic  req_push;
    addr_t req_push_addr;
    logic  req_pop;
    addr_t req_head;
    logic  req_empty;
    logic  req_full;
    logic  req_prog_full;
    logic  resp_push;
    data_t resp_push_data;
    logic  resp_full;
    logic  resp_empty;
    logic  resp_prog_full;
    logic  master_idle;
    logic  setup_pop;

    assign setup_valid = !resp_empty;
    assign setup_pop   = setup_valid && setup_ready;

    cu_setup_ctrl u_ctrl (
        .ap_clk         (ap_clk),
        .areset_cu_setup(areset_cu_setup),
        .desc_valid     (desc_valid),
        .engine_done    (engine_done),
        .engine_busy    (engine_busy),
        .req_empty      (req_empty),
        .req_prog_full  (req_prog_full),
        .resp_prog_full (resp_prog_full),
        .master_idle    (master_idle),
        .engine_start   (engine_start),
        .engine_pause   (engine_pause),
        .done           (done)
    );

    cu_setup_read_engine u_engine (
        .ap_clk         (ap_clk),
        .areset_cu_setup(areset_cu_setup),
        .start          (engine_start),
        .pause          (engine_pause),
        .base           (desc_base),
        .count          (desc_count),
        .req_full       (req_full),
        .req_push       (req_push),
        .req_addr       (req_push_addr),
        .busy           (engine_busy),
        .done           (engine_done)
    );

    // Word addresses waiting for a bus cycle
    cu_setup_sync_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH),
        .WIDTH      (ADDR_W)
    ) u_req_fifo (
        .ap_clk         (ap_clk),
        .areset_cu_setup(areset_cu_setup),
        .push           (req_push),
        .push_data      (req_push_addr),
        .pop            (req_pop),
        .pop_data       (req_head),
        .empty          (req_empty),
        .full           (req_full),
        .prog_full      (req_prog_full)
    );

    cu_setup_wb_master u_wb (
        .ap_clk         (ap_clk),
        .areset_cu_setup(areset_cu_setup),
        .req_empty      (req_empty),
        .req_addr       (req_head),
        .resp_full      (resp_full),
        .wb_ack         (wb_ack),
        .wb_dat_i       (wb_dat_i),
        .req_pop        (req_pop),
        .resp_push      (resp_push),
        .resp_data      (resp_push_data),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_adr         (wb_adr),
        .idle           (master_idle)
    );

    // Returned words in bus order
    cu_setup_sync_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH),
        .WIDTH      (DATA_W)
    ) u_resp_fifo (
        .ap_clk         (ap_clk),
        .areset_cu_setup(areset_cu_setup),
        .push           (resp_push),
        .push_data      (resp_push_data),
        .pop            (setup_pop),
        .pop_data       (setup_data),
        .empty          (resp_empty),
        .full           (resp_full),
        .prog_full      (resp_prog_full)
    );

    // While done is shown, no request is queued and no bus cycle is open
    a_done_quiet : assert property (
        @(posedge ap_clk) disable iff (areset_cu_setup)
        (u_ctrl.state_q == CU_SETUP_DONE) |-> (req_empty && !wb_cyc && !engine_busy)
    ) else $error("done with work still in flight");

endmodule : cu_setup

// File: hw/cu_setup_ctrl.sv
// Descriptor state machine. The descriptor must stay valid until done is seen.
// Pause follows the FIFO levels with one cycle of lag, so thresholds need slack.
module cu_setup_ctrl import cu_setup_pkg::*; (
    input  logic ap_clk,
    input  logic areset_cu_setup,
    input  logic desc_valid,
    input  logic engine_done,
    input  logic engine_busy,
    input  logic req_empty,
    input  logic req_prog_full,
    input  logic resp_prog_full,
    input  logic master_idle,
    output logic engine_start,
    output logic engine_pause,
    output logic done
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    logic any_prog_full;
    logic all_finished;

    assign any_prog_full = req_prog_full || resp_prog_full;

    // Nothing left in the engine, nothing queued, nothing on the bus
    assign all_finished = engine_done && req_empty && master_idle;

    // ------------------------------
    // State register
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            state_q <= CU_SETUP_RESET;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            CU_SETUP_RESET: begin
                state_d = CU_SETUP_IDLE;
            end
            CU_SETUP_IDLE: begin
                if (desc_valid && !engine_busy) begin
                    state_d = CU_SETUP_START;
                end
            end
            CU_SETUP_START: begin
                state_d = CU_SETUP_BUSY;
            end
            CU_SETUP_BUSY: begin
                // Completion wins over a late pause request
                if (all_finished) begin
                    state_d = CU_SETUP_DONE;
                end else if (any_prog_full) begin
                    state_d = CU_SETUP_PAUSE;
                end
            end
            CU_SETUP_PAUSE: begin
                if (!any_prog_full) begin
                    state_d = CU_SETUP_BUSY;
                end
            end
            CU_SETUP_DONE: begin
                // Hold until the source lets go of the descriptor
                if (!desc_valid) begin
                    state_d = CU_SETUP_IDLE;
                end
            end
            default: begin
                state_d = CU_SETUP_RESET;
            end
        endcase
    end

    // ------------------------------
    // Outputs
    // ------------------------------
    assign engine_start = (state_q == CU_SETUP_START);
    assign engine_pause = (state_q == CU_SETUP_PAUSE);
    assign done         = (state_q == CU_SETUP_DONE);

    // A double start would restart the walk mid descriptor
    a_single_start : assert property (
        @(posedge ap_clk) disable iff (areset_cu_setup)
        engine_start |=> !engine_start
    ) else $error("Engine start held for two cycles");

endmodule : cu_setup_ctrl

// File: hw/cu_setup_pkg.sv
// Shared widths and types for the setup unit.
// Addresses are byte addresses. Reads always step by one word.
package cu_setup_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int ADDR_W          = 32;
    localparam int DATA_W          = 32;
    localparam int COUNT_W         = 16;

    // Bytes per word is 2**WORD_BYTES_LOG2
    localparam int WORD_BYTES_LOG2 = 2;

    // ------------------------------
    // Types
    // ------------------------------
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [COUNT_W-1:0] count_t;

    // Descriptor level control states
    typedef enum logic [2:0] {
        CU_SETUP_RESET,
        CU_SETUP_IDLE,
        CU_SETUP_START,
        CU_SETUP_BUSY,
        CU_SETUP_PAUSE,
        CU_SETUP_DONE
    } ctrl_state_t;

endpackage : cu_setup_pkg

// File: hw/cu_setup_read_engine.sv
// Serial word address generator. Start is only honoured while not busy.
// A count of zero finishes right after start without any push.
module cu_setup_read_engine import cu_setup_pkg::*; (
    input  logic   ap_clk,
    input  logic   areset_cu_setup,
    input  logic   start,
    input  logic   pause,
    input  addr_t  base,
    input  count_t count,
    input  logic   req_full,
    output logic   req_push,
    output addr_t  req_addr,
    output logic   busy,
    output logic   done
);

    // One word in bytes
    localparam addr_t WORD_STEP = addr_t'(1) << WORD_BYTES_LOG2;

    // ------------------------------
    // Walk state
    // ------------------------------
    addr_t  cur_addr;
    count_t remaining;
    logic   busy_q;
    logic   done_q;
    logic   last_push;

    // A push goes out whenever there is work and room
    assign req_push  = busy_q && !pause && !req_full;
    assign last_push = req_push && (remaining == count_t'(1));

    // Control flags
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (start && !busy_q) begin
            busy_q <= (count != '0);
            done_q <= (count == '0);
        end else if (last_push) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
        end
    end

    // Address and count only matter while busy
    always_ff @(posedge ap_clk) begin
        if (start && !busy_q) begin
            cur_addr  <= base;
            remaining <= count;
        end else if (req_push) begin
            cur_addr  <= cur_addr + WORD_STEP;
            remaining <= remaining - count_t'(1);
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------
    assign req_addr = cur_addr;
    assign busy     = busy_q;
    assign done     = done_q;

    a_no_push_full : assert property (
        @(posedge ap_clk) disable iff (areset_cu_setup)
        req_push |-> !req_full
    ) else $error("Engine pushed into a full request FIFO");

endmodule : cu_setup_read_engine

// File: hw/cu_setup_sync_fifo.sv
// First-word-fall-through FIFO, single clock. FIFO_DEPTH must be a power of two
// and PROG_THRESH must be below FIFO_DEPTH. Pushing while full or popping while
// empty is illegal; the caller gates both.
module cu_setup_sync_fifo #(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 12,
    parameter int WIDTH       = 32
) (
    input  logic             ap_clk,
    input  logic             areset_cu_setup,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] pop_data,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    // ------------------------------
    // Storage and pointers
    // ------------------------------
    logic [WIDTH-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;

    // Pointers wrap naturally since the depth is a power of two
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // ------------------------------
    // Status and head
    // ------------------------------
    // Head word is visible as soon as empty drops
    assign pop_data  = mem[rd_ptr];
    assign empty     = (fill == '0);
    assign full      = (fill == CNT_W'(FIFO_DEPTH));
    assign prog_full = (fill >= CNT_W'(PROG_THRESH));

    // Overflow would corrupt the oldest entry
    a_no_push_full : assert property (
        @(posedge ap_clk) disable iff (areset_cu_setup)
        push |-> !full
    ) else $error("FIFO pushed while full");

    a_no_pop_empty : assert property (
        @(posedge ap_clk) disable iff (areset_cu_setup)
        pop |-> !empty
    ) else $error("FIFO popped while empty");

endmodule : cu_setup_sync_fifo

// File: hw/cu_setup_wb_master.sv
// Wishbone classic read master, one outstanding cycle at a time.
// A request is taken only while the response FIFO has room for its word.
module cu_setup_wb_master import cu_setup_pkg::*; (
    input  logic  ap_clk,
    input  logic  areset_cu_setup,
    input  logic  req_empty,
    input  addr_t req_addr,
    input  logic  resp_full,
    input  logic  wb_ack,
    input  data_t wb_dat_i,
    output logic  req_pop,
    output logic  resp_push,
    output data_t resp_data,
    output logic  wb_cyc,
    output logic  wb_stb,
    output addr_t wb_adr,
    output logic  idle
);

    typedef enum logic {
        WB_IDLE,
        WB_CYCLE
    } wb_state_t;

    wb_state_t state_q;
    addr_t     adr_q;

    assign req_pop = (state_q == WB_IDLE) && !req_empty && !resp_full;

    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            state_q <= WB_IDLE;
        end else if (req_pop) begin
            state_q <= WB_CYCLE;
        end else if ((state_q == WB_CYCLE) && wb_ack) begin
            // Back to idle drops cyc for at least one cycle
            state_q <= WB_IDLE;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (req_pop) begin
            adr_q <= req_addr;
        end
    end

    // ------------------------------
    // Bus and response side
    // ------------------------------
    assign wb_cyc    = (state_q == WB_CYCLE);
    assign wb_stb    = (state_q == WB_CYCLE);
    assign wb_adr    = adr_q;
    assign resp_push = (state_q == WB_CYCLE) && wb_ack;
    assign resp_data = wb_dat_i;
    assign idle      = (state_q == WB_IDLE);

    a_stb_cyc : assert property (
        @(posedge ap_clk) disable iff (areset_cu_setup)
        wb_stb |-> wb_cyc
    ) else $error("wb_stb without wb_cyc");

    a_adr_stable : assert property (
        @(posedge ap_clk) disable iff (areset_cu_setup)
        wb_stb && !wb_ack |=> $stable(wb_adr)
    ) else $error("wb_adr changed during a pending cycle");

endmodule : cu_setup_wb_master

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the setup unit testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.
set -u

cd "$(dirname "$0")" || exit 1

TOP=cu_setup_tb
OBJ_DIR=obj_dir
LOG=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator was not found in PATH"
    exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module "$TOP" -Mdir "$OBJ_DIR" -f build.f; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: verification/cu_setup_tb.sv
// Random descriptors against a memory model with random ack delay and stream stalls.
// Needs a simulator with timing support. The run stops at the first mismatch.
module cu_setup_tb import cu_setup_pkg::*; ();

    localparam int unsigned SEED            = 32'hd77d_a8e1;
    localparam int          NUM_DESC        = 21;
    localparam int          ZERO_DESC       = 10;
    localparam int          MAX_COUNT       = 40;
    localparam int          MAX_ACK_WAIT    = 3;
    localparam data_t       MEM_KEY         = 32'h5a3c_96e1;
    localparam int          CYCLES_PER_WORD = 200;
    localparam int          CYCLES_SLACK    = 1000;

    logic   ap_clk;
    logic   areset_cu_setup;
    logic   desc_valid;
    addr_t  desc_base;
    count_t desc_count;
    logic   wb_cyc;
    logic   wb_stb;
    addr_t  wb_adr;
    logic   wb_ack;
    data_t  wb_dat_i;
    logic   setup_valid;
    data_t  setup_data;
    logic   setup_ready;
    logic   done;

    // Descriptor list and expected traffic
    addr_t  desc_bases [NUM_DESC];
    count_t desc_counts [NUM_DESC];
    addr_t  exp_addr [$];
    data_t  exp_data [$];
    int     acks_in_desc;
    int     total_words;
    logic   descs_ready;
    logic   ack_seen;

    cu_setup_tb_clk u_clk (
        .ap_clk         (ap_clk),
        .areset_cu_setup(areset_cu_setup)
    );

    cu_setup #(
        .FIFO_DEPTH (16),
        .PROG_THRESH(12)
    ) u_dut (
        .ap_clk         (ap_clk),
        .areset_cu_setup(areset_cu_setup),
        .desc_valid     (desc_valid),
        .desc_base      (desc_base),
        .desc_count     (desc_count),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_adr         (wb_adr),
        .wb_ack         (wb_ack),
        .wb_dat_i       (wb_dat_i),
        .setup_valid    (setup_valid),
        .setup_data     (setup_data),
        .setup_ready    (setup_ready),
        .done           (done)
    );

    // ------------------------------
    // Helpers
    // ------------------------------
    // Memory content is the word address scrambled by a fixed key
    function automatic data_t mem_word(input addr_t adr);
        return data_t'(adr >> WORD_BYTES_LOG2) ^ MEM_KEY;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "Check %s failed", name);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "Run aborted");
    endtask

    task automatic next_cycle();
        @(posedge ap_clk);
        #1;
    endtask

    task automatic make_descriptors();
        total_words = 0;
        for (int i = 0; i < NUM_DESC; i++) begin
            desc_bases[i] = addr_t'($urandom) & 32'hffff_fffc;
            if (i == ZERO_DESC) begin
                desc_counts[i] = '0;
            end else begin
                desc_counts[i] = count_t'($urandom_range(1, MAX_COUNT));
            end
            total_words += int'(desc_counts[i]);
        end
    endtask

    // Queue the expected words, then run the descriptor handshake to the end
    task automatic run_descriptor(input int idx);
        addr_t adr;
        int    hold;
        adr = desc_bases[idx];
        for (int n = 0; n < int'(desc_counts[idx]); n++) begin
            exp_addr.push_back(adr);
            exp_data.push_back(mem_word(adr));
            adr = adr + addr_t'(1 << WORD_BYTES_LOG2);
        end
        acks_in_desc = 0;
        desc_base  = desc_bases[idx];
        desc_count = desc_counts[idx];
        desc_valid = 1'b1;
        while (!done) begin
            next_cycle();
        end
        check_value("acks_at_done", desc_counts[idx], acks_in_desc);
        hold = $urandom_range(0, 3);
        repeat (hold) begin
            next_cycle();
            check_value("done_held", 1, done);
        end
        desc_valid = 1'b0;
        while (done) begin
            next_cycle();
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        void'($urandom(SEED));
        desc_valid  = 1'b0;
        desc_base   = '0;
        desc_count  = '0;
        descs_ready = 1'b0;
        make_descriptors();
        descs_ready = 1'b1;
        wait (!areset_cu_setup);
        check_value("reset_wb_cyc", 0, wb_cyc);
        check_value("reset_wb_stb", 0, wb_stb);
        check_value("reset_setup_valid", 0, setup_valid);
        check_value("reset_done", 0, done);
        for (int i = 0; i < NUM_DESC; i++) begin
            run_descriptor(i);
        end
        // Words may still sit in the response FIFO after done
        while (exp_data.size() != 0) begin
            next_cycle();
        end
        // Any word still offered now would be a duplicate
        check_value("stream_idle_at_end", 0, setup_valid);
        $display("Finished with no errors");
        $finish;
    end

    // Stream sink, ready about half the time with the odd long stall
    initial begin
        int stall_left;
        setup_ready = 1'b0;
        stall_left  = 0;
        wait (!areset_cu_setup);
        forever begin
            if (stall_left > 0) begin
                setup_ready = 1'b0;
                stall_left--;
            end else if ($urandom_range(0, 19) == 0) begin
                setup_ready = 1'b0;
                stall_left  = $urandom_range(20, 60);
            end else begin
                setup_ready = logic'($urandom_range(0, 1));
            end
            next_cycle();
        end
    end

    // Wishbone slave memory, ack after 0 to MAX_ACK_WAIT extra cycles
    initial begin
        int wait_n;
        wb_ack   = 1'b0;
        wb_dat_i = '0;
        forever begin
            @(posedge ap_clk);
            if (wb_ack) begin
                #1;
                wb_ack = 1'b0;
            end else if (!areset_cu_setup && wb_cyc && wb_stb) begin
                wait_n = $urandom_range(0, MAX_ACK_WAIT);
                repeat (wait_n) @(posedge ap_clk);
                #1;
                wb_dat_i = mem_word(wb_adr);
                wb_ack   = 1'b1;
            end
        end
    end

    // ------------------------------
    // Bus and stream monitor
    // ------------------------------
    always @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            ack_seen = 1'b0;
        end else begin
            if (wb_stb) begin
                check_value("stb_needs_cyc", 1, wb_cyc);
            end
            if (ack_seen) begin
                check_value("cyc_low_after_ack", 0, wb_cyc);
            end
            ack_seen = wb_cyc && wb_ack;
            if (wb_cyc && wb_stb && wb_ack) begin
                if (exp_addr.size() == 0) begin
                    abort_run("A bus cycle was acked while no address was expected");
                end else begin
                    check_value("wb_adr", exp_addr[0], wb_adr);
                    void'(exp_addr.pop_front());
                    acks_in_desc++;
                end
            end
            if (setup_valid && setup_ready) begin
                if (exp_data.size() == 0) begin
                    abort_run("The stream delivered a word while none was expected");
                end else begin
                    check_value("setup_data", exp_data[0], setup_data);
                    void'(exp_data.pop_front());
                end
            end
        end
    end

    // Watchdog scaled by the total number of words
    initial begin
        int limit;
        wait (descs_ready);
        limit = total_words * CYCLES_PER_WORD + CYCLES_SLACK;
        repeat (limit) @(posedge ap_clk);
        abort_run($sformatf("Timeout after %0d cycles, the DUT stopped making progress", limit));
    end

endmodule : cu_setup_tb

// File: verification/cu_setup_tb_clk.sv
// Free-running clock with a period of 10 time units.
// Reset is held high for the first 3 rising edges and released just after the third.
module cu_setup_tb_clk (
    output logic ap_clk,
    output logic areset_cu_setup
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 3;

    initial begin
        ap_clk = 1'b0;
        forever #HALF_PERIOD ap_clk = ~ap_clk;
    end

    // Released off the edge like every other driven input
    initial begin
        areset_cu_setup = 1'b1;
        repeat (RESET_CYCLES) @(posedge ap_clk);
        #1;
        areset_cu_setup = 1'b0;
    end

endmodule : cu_setup_tb_clk
